/* logic/vreadPkg.sv */
package vreadPkg;

   localparam int BUS_W      = 32;
   localparam int DATA_W     = 16;
   localparam int WB_ADDR_W  = 32;
   localparam int BUF_ADDR_W = 8;
   localparam int SYM_W      = 8;
   localparam int LEN_W      = 8;
   localparam int PERIOD_W   = 10;
   localparam int ITER_W     = 8;

   typedef struct packed {
      logic [WB_ADDR_W-1:0] extAddr;
      logic [LEN_W-1:0]     length;
   } fetchCfg_t;

   // outer loop of the two-level pattern steps by incr2
   typedef struct packed {
      logic [SYM_W-1:0]    start;
      logic [SYM_W-1:0]    incr;
      logic [SYM_W-1:0]    shift;
      logic [SYM_W-1:0]    incr2;
      logic [ITER_W-1:0]   iterations;
      logic [ITER_W-1:0]   iter2;
      logic [PERIOD_W-1:0] period;
      logic [PERIOD_W-1:0] duty;
      logic [PERIOD_W-1:0] delay;
      logic                reverse;
   } streamCfg_t;

   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [3:0]           sel;
      logic [WB_ADDR_W-1:0] adr;
   } wbReq_t;

   typedef struct packed {
      logic                  en;
      logic [BUF_ADDR_W-1:0] addr;
      logic [BUS_W-1:0]      data;
   } bufWrite_t;

   // symAddr bit 0 picks the lane
   typedef struct packed {
      logic             en;
      logic             half;
      logic [SYM_W-1:0] symAddr;
   } bufRead_t;

   typedef enum logic [1:0] {FETCH_IDLE, FETCH_BUS, FETCH_DONE} fetchState_t;

   typedef enum logic [1:0] {GEN_IDLE, GEN_DELAY, GEN_RUN, GEN_DONE} genState_t;

endpackage

/* logic/busFetcher.sv */
`timescale 1ns/1ns

module busFetcher (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         start,
   input  vreadPkg::fetchCfg_t          cfg,
   input  logic                         writeHalf,
   output vreadPkg::wbReq_t             wbReq,
   input  logic [vreadPkg::BUS_W-1:0]   wbDatI,
   input  logic                         wbAck,
   output vreadPkg::bufWrite_t          bufWr,
   output logic                         fetchDone
);

   vreadPkg::fetchState_t              state;
   logic                               cycQ;
   logic                               stbQ;
   logic [vreadPkg::WB_ADDR_W-1:0]     adrQ;
   logic [vreadPkg::LEN_W-1:0]         wordCnt;
   logic                               accept;
   logic                               lastWord;

   assign accept   = (state == vreadPkg::FETCH_BUS) && cycQ && stbQ && wbAck;
   assign lastWord = (wordCnt == cfg.length - vreadPkg::LEN_W'(1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= vreadPkg::FETCH_IDLE;
         cycQ    <= 1'b0;
         stbQ    <= 1'b0;
         wordCnt <= '0;
      end else if (start) begin
         state   <= vreadPkg::FETCH_BUS;
         cycQ    <= 1'b1;
         stbQ    <= 1'b1;
         wordCnt <= '0;
      end else if (state == vreadPkg::FETCH_BUS) begin
         if (accept) begin
            // drop the strobe for one cycle between words
            cycQ    <= 1'b0;
            stbQ    <= 1'b0;
            wordCnt <= wordCnt + vreadPkg::LEN_W'(1);
            if (lastWord) begin
               state <= vreadPkg::FETCH_DONE;
            end
         end else if (!cycQ) begin
            cycQ <= 1'b1;
            stbQ <= 1'b1;
         end
      end
   end

   // byte address of the next word
   always_ff @(posedge clk) begin
      if (start) begin
         adrQ <= cfg.extAddr;
      end else if (accept) begin
         adrQ <= adrQ + vreadPkg::WB_ADDR_W'(4);
      end
   end

   always_comb begin
      wbReq.cyc = cycQ;
      wbReq.stb = stbQ;
      wbReq.we  = 1'b0;
      wbReq.sel = 4'hf;
      wbReq.adr = adrQ;
   end

   // returned word goes straight into the selected half
   always_comb begin
      bufWr.en   = accept;
      bufWr.addr = {writeHalf, wordCnt[vreadPkg::BUF_ADDR_W-2:0]};
      bufWr.data = wbDatI;
   end

   assign fetchDone = (state == vreadPkg::FETCH_DONE) || (accept && lastWord);

endmodule

/* logic/streamAddrGen.sv */
`timescale 1ns/1ns

module streamAddrGen (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start,
   input  vreadPkg::streamCfg_t   cfg,
   input  logic                   readHalf,
   output vreadPkg::bufRead_t     rdReq,
   output logic                   genDone
);

   vreadPkg::genState_t              state;
   logic [vreadPkg::PERIOD_W-1:0]    delayCnt;
   logic [vreadPkg::PERIOD_W-1:0]    stepCnt;
   logic [vreadPkg::ITER_W-1:0]      iterCnt;
   logic [vreadPkg::ITER_W-1:0]      outerCnt;
   logic [vreadPkg::SYM_W-1:0]       outerBase;
   logic [vreadPkg::SYM_W-1:0]       iterBase;
   logic [vreadPkg::SYM_W-1:0]       addrCur;
   logic [vreadPkg::SYM_W-1:0]       revAddr;
   logic                             emptyRun;
   logic                             stepEnd;
   logic                             lastIter;
   logic                             lastOuter;
   logic                             en;
   logic                             lastEn;
   logic                             finish;

   assign emptyRun  = (cfg.iterations == '0) || (cfg.iter2 == '0) || (cfg.period == '0);
   assign stepEnd   = (stepCnt == cfg.period - vreadPkg::PERIOD_W'(1));
   assign lastIter  = (iterCnt == cfg.iterations - vreadPkg::ITER_W'(1));
   assign lastOuter = (outerCnt == cfg.iter2 - vreadPkg::ITER_W'(1));

   // enable only in the duty part of each period
   assign en     = (state == vreadPkg::GEN_RUN) && (stepCnt < cfg.duty);
   assign lastEn = en && lastIter && lastOuter &&
                   (stepCnt == cfg.duty - vreadPkg::PERIOD_W'(1));
   assign finish = (state == vreadPkg::GEN_RUN) &&
                   (lastEn || (stepEnd && lastIter && lastOuter));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= vreadPkg::GEN_IDLE;
         delayCnt <= '0;
         stepCnt  <= '0;
         iterCnt  <= '0;
         outerCnt <= '0;
      end else if (start) begin
         delayCnt <= cfg.delay;
         stepCnt  <= '0;
         iterCnt  <= '0;
         outerCnt <= '0;
         if (emptyRun) begin
            state <= vreadPkg::GEN_DONE;
         end else if (cfg.delay == '0) begin
            state <= vreadPkg::GEN_RUN;
         end else begin
            state <= vreadPkg::GEN_DELAY;
         end
      end else begin
         case (state)
            vreadPkg::GEN_DELAY: begin
               delayCnt <= delayCnt - vreadPkg::PERIOD_W'(1);
               if (delayCnt == vreadPkg::PERIOD_W'(1)) begin
                  state <= vreadPkg::GEN_RUN;
               end
            end
            vreadPkg::GEN_RUN: begin
               if (finish) begin
                  state <= vreadPkg::GEN_DONE;
               end else if (stepEnd) begin
                  stepCnt <= '0;
                  if (lastIter) begin
                     iterCnt  <= '0;
                     outerCnt <= outerCnt + vreadPkg::ITER_W'(1);
                  end else begin
                     iterCnt <= iterCnt + vreadPkg::ITER_W'(1);
                  end
               end else begin
                  stepCnt <= stepCnt + vreadPkg::PERIOD_W'(1);
               end
            end
            default: begin
               state <= state;
            end
         endcase
      end
   end

   // running bases wrap at 256
   always_ff @(posedge clk) begin
      if (start) begin
         outerBase <= cfg.start;
         iterBase  <= cfg.start;
         addrCur   <= cfg.start;
      end else if (state == vreadPkg::GEN_RUN) begin
         if (stepEnd) begin
            if (lastIter) begin
               outerBase <= outerBase + cfg.incr2;
               iterBase  <= outerBase + cfg.incr2;
               addrCur   <= outerBase + cfg.incr2;
            end else begin
               iterBase <= iterBase + cfg.shift;
               addrCur  <= iterBase + cfg.shift;
            end
         end else begin
            addrCur <= addrCur + cfg.incr;
         end
      end
   end

   always_comb begin
      for (int b = 0; b < vreadPkg::SYM_W; b++) begin
         revAddr[b] = addrCur[vreadPkg::SYM_W-1-b];
      end
   end

   always_comb begin
      rdReq.en      = en;
      rdReq.half    = readHalf;
      rdReq.symAddr = cfg.reverse ? revAddr : addrCur;
   end

   // high from the cycle of the last outValid
   assign genDone = (state == vreadPkg::GEN_DONE);

endmodule

/* logic/pingPongBuffer.sv */
`timescale 1ns/1ns

module pingPongBuffer (
   input  logic                          clk,
   input  logic                          rst,
   input  vreadPkg::bufWrite_t           wr,
   input  vreadPkg::bufRead_t            rd,
   output logic [vreadPkg::DATA_W-1:0]   outData,
   output logic                          outValid
);

   localparam int DEPTH = 1 << vreadPkg::BUF_ADDR_W;

   logic [vreadPkg::BUS_W-1:0]       mem [DEPTH];
   logic [vreadPkg::BUF_ADDR_W-1:0]  rdAddr;
   logic [vreadPkg::BUS_W-1:0]       rdWord;
   logic                             laneQ;
   logic                             validQ;

   // half bit on top, symbol word index below
   assign rdAddr = {rd.half, rd.symAddr[vreadPkg::SYM_W-1:1]};

   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   always_ff @(posedge clk) begin
      if (rd.en) begin
         rdWord <= mem[rdAddr];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         laneQ  <= 1'b0;
         validQ <= 1'b0;
      end else begin
         laneQ  <= rd.symAddr[0];
         validQ <= rd.en;
      end
   end

   // lane 0 is the low half of the word
   assign outData  = laneQ ? rdWord[vreadPkg::BUS_W-1:vreadPkg::DATA_W]
                           : rdWord[vreadPkg::DATA_W-1:0];
   assign outValid = validQ;

endmodule

/* logic/vreadUnit.sv */
`timescale 1ns/1ns

module vreadUnit (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          run,
   input  logic                          disabled,
   input  logic                          pingPong,
   input  vreadPkg::fetchCfg_t           fetchCfg,
   input  vreadPkg::streamCfg_t          streamCfg,
   output vreadPkg::wbReq_t              wbReq,
   input  logic [vreadPkg::BUS_W-1:0]    wbDatI,
   input  logic                          wbAck,
   output logic [vreadPkg::DATA_W-1:0]   outData,
   output logic                          outValid,
   output logic                          done
);

   vreadPkg::fetchCfg_t    fetchCfgQ;
   vreadPkg::streamCfg_t   streamCfgQ;
   vreadPkg::bufWrite_t    bufWr;
   vreadPkg::bufRead_t     rdReq;
   logic                   start;
   logic                   startQ;
   logic                   pingPongQ;
   logic                   writeHalf;
   logic                   readHalf;
   logic                   fetchDone;
   logic                   genDone;
   logic                   fetchFin;
   logic                   genFin;

   // starts while busy are dropped
   assign start = run && !disabled && done;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         startQ    <= 1'b0;
         pingPongQ <= 1'b0;
         writeHalf <= 1'b0;
         fetchFin  <= 1'b1;
         genFin    <= 1'b1;
      end else begin
         startQ <= start;
         if (start) begin
            pingPongQ <= pingPong;
            writeHalf <= pingPong ? !writeHalf : 1'b0;
            fetchFin  <= 1'b0;
            genFin    <= 1'b0;
         end else if (!startQ) begin
            // both blocks still show the previous run while startQ is high
            if (fetchDone) begin
               fetchFin <= 1'b1;
            end
            if (genDone) begin
               genFin <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         fetchCfgQ  <= fetchCfg;
         streamCfgQ <= streamCfg;
      end
   end

   assign readHalf = pingPongQ ? !writeHalf : 1'b0;
   assign done     = fetchFin && genFin;

   busFetcher fetcher_inst (
      .clk       (clk),
      .rst       (rst),
      .start     (startQ),
      .cfg       (fetchCfgQ),
      .writeHalf (writeHalf),
      .wbReq     (wbReq),
      .wbDatI    (wbDatI),
      .wbAck     (wbAck),
      .bufWr     (bufWr),
      .fetchDone (fetchDone)
   );

   streamAddrGen addrGen_inst (
      .clk      (clk),
      .rst      (rst),
      .start    (startQ),
      .cfg      (streamCfgQ),
      .readHalf (readHalf),
      .rdReq    (rdReq),
      .genDone  (genDone)
   );

   pingPongBuffer buffer_inst (
      .clk      (clk),
      .rst      (rst),
      .wr       (bufWr),
      .rd       (rdReq),
      .outData  (outData),
      .outValid (outValid)
   );

endmodule

/* testbench/wbSlaveModel.sv */
`timescale 1ns/1ns

module wbSlaveModel #(
   parameter int MAX_DELAY = 3
) (
   input  logic                         clk,
   input  logic                         rst,
   input  vreadPkg::wbReq_t             wbReq,
   output logic [vreadPkg::BUS_W-1:0]   wbDatI,
   output logic                         wbAck
);

   logic pending;
   int   waitCnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wbAck   <= 1'b0;
         wbDatI  <= '0;
         pending <= 1'b0;
         waitCnt <= 0;
      end else if (wbAck) begin
         // master takes the word on this edge and drops stb
         wbAck   <= 1'b0;
         pending <= 1'b0;
      end else if (wbReq.cyc && wbReq.stb) begin
         if (!pending) begin
            pending <= 1'b1;
            waitCnt <= $urandom_range(MAX_DELAY, 0);
         end else if (waitCnt > 0) begin
            waitCnt <= waitCnt - 1;
         end else begin
            wbAck  <= 1'b1;
            // word address with a fixed pattern on top
            wbDatI <= (wbReq.adr >> 2) ^ 32'h5a5a0000;
         end
      end
   end

endmodule

/* testbench/vreadUnit_assert.sv */
`timescale 1ns/1ns

module vreadUnit_assert (
   input logic               clk,
   input logic               rst,
   input vreadPkg::wbReq_t   wbReq,
   input logic               wbAck,
   input logic               done,
   input logic               rdEn,
   input logic               outValid
);

   int failCount = 0;

   stbNeedsCyc: assert property (@(posedge clk) disable iff (rst) wbReq.stb |-> wbReq.cyc)
      else begin
         $error("stb high without cyc");
         failCount++;
      end

   // address held until the slave answers
   adrStable: assert property (@(posedge clk) disable iff (rst)
      (wbReq.stb && !wbAck) |=> $stable(wbReq.adr))
      else begin
         $error("adr changed while waiting for ack");
         failCount++;
      end

   idleWhenDone: assert property (@(posedge clk) disable iff (rst) done |-> !wbReq.cyc)
      else begin
         $error("cyc high while done is high");
         failCount++;
      end

   validFollowsRead: assert property (@(posedge clk) disable iff (rst) rdEn |=> outValid)
      else begin
         $error("buffer read not followed by outValid");
         failCount++;
      end

endmodule

/* testbench/vreadTb.sv */
`timescale 1ns/1ns

module vreadTb;

   localparam logic [31:0] SEED        = 32'hc7b5f78a;
   localparam int          NUM_RUNS    = 12;
   localparam int          MAX_ACK_DLY = 3;
   localparam int          DRIVE_DLY   = 10;

   logic                          clk;
   logic                          rst;
   logic                          run;
   logic                          disabled;
   logic                          pingPong;
   vreadPkg::fetchCfg_t           fetchCfg;
   vreadPkg::streamCfg_t          streamCfg;
   vreadPkg::wbReq_t              wbReq;
   logic [vreadPkg::BUS_W-1:0]    wbDatI;
   logic                          wbAck;
   logic [vreadPkg::DATA_W-1:0]   outData;
   logic                          outValid;
   logic                          done;

   vreadPkg::fetchCfg_t    fetchCfgs [NUM_RUNS];
   vreadPkg::streamCfg_t   streamCfgs [NUM_RUNS];
   logic [31:0]            modelMem [256];
   logic                   modelWriteHalf;
   logic [15:0]            expSyms [$];
   logic [15:0]            gotSyms [$];
   logic [31:0]            busAddrs [$];
   int                     cycCount;
   int                     ackWhileDone;
   int                     badReqs;
   int                     testErrors;
   int                     errorCount;
   int                     testsRun;
   int                     testsFailed;
   int                     watchdogCycles;

   vreadUnit vreadUnit_inst (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .disabled  (disabled),
      .pingPong  (pingPong),
      .fetchCfg  (fetchCfg),
      .streamCfg (streamCfg),
      .wbReq     (wbReq),
      .wbDatI    (wbDatI),
      .wbAck     (wbAck),
      .outData   (outData),
      .outValid  (outValid),
      .done      (done)
   );

   wbSlaveModel #(.MAX_DELAY(MAX_ACK_DLY)) slave_inst (
      .clk    (clk),
      .rst    (rst),
      .wbReq  (wbReq),
      .wbDatI (wbDatI),
      .wbAck  (wbAck)
   );

   bind vreadUnit vreadUnit_assert checks_inst (
      .clk      (clk),
      .rst      (rst),
      .wbReq    (wbReq),
      .wbAck    (wbAck),
      .done     (done),
      .rdEn     (rdReq.en),
      .outValid (outValid)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // sampled mid-cycle, away from the clock edge
   always @(negedge clk) begin
      if (!rst) begin
         if (outValid)
            gotSyms.push_back(outData);
         if (wbReq.cyc)
            cycCount++;
         if (wbReq.cyc && wbReq.stb && wbAck) begin
            busAddrs.push_back(wbReq.adr);
            if (done)
               ackWhileDone++;
            // full-word reads only
            if (wbReq.we || wbReq.sel !== 4'hf)
               badReqs++;
         end
      end
   end

   initial begin
      wait (watchdogCycles > 0);
      repeat (watchdogCycles) @(posedge clk);
      $display("timeout: the runs did not finish within %0d cycles", watchdogCycles);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERR %s expected %0h actual %0h", name, expected, actual);
         testErrors++;
      end
   endtask

   task automatic finishTest(input string name);
      testsRun++;
      if (testErrors == 0) begin
         $display("test %s: ok", name);
      end else begin
         testsFailed++;
         errorCount += testErrors;
         $display("test %s: %0d mismatches", name, testErrors);
      end
      testErrors = 0;
   endtask

   function automatic logic [7:0] reverseBits(input logic [7:0] a);
      logic [7:0] r;
      for (int b = 0; b < 8; b++)
         r[b] = a[7 - b];
      return r;
   endfunction

   // symbols ordered by outer, inner, then step within the period
   task automatic buildExpected(input vreadPkg::streamCfg_t s, input logic half);
      logic [7:0]  sym;
      logic [31:0] word;
      expSyms.delete();
      for (int o = 0; o < s.iter2; o++) begin
         for (int i = 0; i < s.iterations; i++) begin
            for (int k = 0; k < s.period && k < s.duty; k++) begin
               sym = s.start + 8'(o * s.incr2) + 8'(i * s.shift) + 8'(k * s.incr);
               if (s.reverse)
                  sym = reverseBits(sym);
               word = modelMem[{half, sym[7:1]}];
               expSyms.push_back(sym[0] ? word[31:16] : word[15:0]);
            end
         end
      end
   endtask

   function automatic vreadPkg::fetchCfg_t randomFetch(input int minLen);
      vreadPkg::fetchCfg_t f;
      f.extAddr = $urandom & 32'hffff_fffc;
      f.length  = 8'($urandom_range(128, minLen));
      return f;
   endfunction

   function automatic vreadPkg::streamCfg_t randomPattern(input logic rev);
      vreadPkg::streamCfg_t s;
      s.start      = 8'($urandom);
      s.incr       = 8'($urandom);
      s.shift      = 8'($urandom);
      s.incr2      = 8'($urandom);
      s.iterations = 8'($urandom_range(8, 1));
      s.iter2      = 8'($urandom_range(4, 1));
      s.period     = 10'($urandom_range(8, 2));
      s.duty       = 10'($urandom_range(int'(s.period) - 1, 1));
      s.delay      = 10'($urandom_range(15, 0));
      s.reverse    = rev;
      return s;
   endfunction

   task automatic doRun(input string name, input vreadPkg::fetchCfg_t f,
                        input vreadPkg::streamCfg_t s, input bit busyPulse);
      logic [31:0] word;
      // the stream reads the half that the previous fetch filled
      modelWriteHalf = !modelWriteHalf;
      buildExpected(s, !modelWriteHalf);
      gotSyms.delete();
      busAddrs.delete();
      ackWhileDone = 0;
      badReqs      = 0;
      @(posedge clk);
      #DRIVE_DLY;
      run       = 1'b1;
      fetchCfg  = f;
      streamCfg = s;
      @(posedge clk);
      #DRIVE_DLY;
      run = 1'b0;
      if (busyPulse) begin
         repeat (2) @(posedge clk);
         #DRIVE_DLY;
         run = 1'b1;
         @(posedge clk);
         #DRIVE_DLY;
         run = 1'b0;
      end
      @(negedge clk);
      while (!done)
         @(negedge clk);
      repeat (2) @(negedge clk);
      check({name, " symbol count"}, expSyms.size(), gotSyms.size());
      for (int n = 0; n < expSyms.size() && n < gotSyms.size(); n++)
         check(name, expSyms[n], gotSyms[n]);
      check({name, " read count"}, f.length, busAddrs.size());
      for (int n = 0; n < busAddrs.size(); n++)
         check({name, " address"}, f.extAddr + 32'(4 * n), busAddrs[n]);
      check({name, " ack with done"}, 0, ackWhileDone);
      check({name, " request type"}, 0, badReqs);
      for (int n = 0; n < f.length; n++) begin
         word = ((f.extAddr >> 2) + 32'(n)) ^ 32'h5a5a0000;
         modelMem[{modelWriteHalf, 7'(n)}] = word;
      end
      finishTest(name);
   endtask

   task automatic ignoredStart(input string name);
      gotSyms.delete();
      busAddrs.delete();
      cycCount = 0;
      @(posedge clk);
      #DRIVE_DLY;
      run      = 1'b1;
      disabled = 1'b1;
      @(posedge clk);
      #DRIVE_DLY;
      run      = 1'b0;
      disabled = 1'b0;
      repeat (20) @(negedge clk);
      check({name, " bus cycles"}, 0, cycCount);
      check({name, " outValid"}, 0, gotSyms.size());
      check({name, " done"}, 1, done);
      finishTest(name);
   endtask

   initial begin
      void'($urandom(SEED));
      rst            = 1'b1;
      run            = 1'b0;
      disabled       = 1'b0;
      pingPong       = 1'b1;
      fetchCfg       = '0;
      streamCfg      = '0;
      modelWriteHalf = 1'b0;
      testErrors     = 0;
      errorCount     = 0;
      testsRun       = 0;
      testsFailed    = 0;
      for (int a = 0; a < 256; a++)
         modelMem[a] = 'x;

      // run 0 fills half 1, run 1 streams it back linearly
      fetchCfgs[0]             = randomFetch(1);
      streamCfgs[0]            = '0;
      fetchCfgs[1]             = randomFetch(128);
      streamCfgs[1]            = '0;
      streamCfgs[1].iterations = fetchCfgs[0].length;
      streamCfgs[1].iter2      = 8'd2;
      streamCfgs[1].shift      = 8'd1;
      streamCfgs[1].incr2      = fetchCfgs[0].length;
      streamCfgs[1].period     = 10'd1;
      streamCfgs[1].duty       = 10'd1;
      for (int r = 2; r < NUM_RUNS; r++) begin
         fetchCfgs[r]  = randomFetch(r == 2 ? 128 : 16);
         streamCfgs[r] = randomPattern((r % 2) == 1);
      end

      watchdogCycles = 20 * 40;
      for (int r = 0; r < NUM_RUNS; r++) begin
         watchdogCycles += 20 * (fetchCfgs[r].length + streamCfgs[r].iter2 *
            streamCfgs[r].iterations * streamCfgs[r].period + streamCfgs[r].delay + 20);
      end

      repeat (3) @(posedge clk);
      #DRIVE_DLY;
      rst = 1'b0;

      // idle outputs straight after reset
      check("reset done", 1, done);
      check("reset cyc", 0, wbReq.cyc);
      check("reset stb", 0, wbReq.stb);
      check("reset we", 0, wbReq.we);
      check("reset outValid", 0, outValid);
      finishTest("reset");

      doRun("fetchOnly", fetchCfgs[0], streamCfgs[0], 1'b0);
      doRun("linear", fetchCfgs[1], streamCfgs[1], 1'b0);
      doRun("pattern", fetchCfgs[2], streamCfgs[2], 1'b0);
      ignoredStart("disabledStart");
      for (int r = 3; r < NUM_RUNS - 1; r++)
         doRun((r % 2) == 1 ? "reverse" : "pingPong", fetchCfgs[r], streamCfgs[r], 1'b0);
      doRun("busyStart", fetchCfgs[NUM_RUNS-1], streamCfgs[NUM_RUNS-1], 1'b1);

      errorCount += vreadUnit_inst.checks_inst.failCount;
      $display("%0d tests, %0d passed, %0d failed, %0d assertion failures", testsRun,
               testsRun - testsFailed, testsFailed, vreadUnit_inst.checks_inst.failCount);
      if (errorCount == 0 && testsFailed == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* build.f */
logic/vreadPkg.sv
logic/busFetcher.sv
logic/streamAddrGen.sv
logic/pingPongBuffer.sv
logic/vreadUnit.sv
testbench/wbSlaveModel.sv
testbench/vreadUnit_assert.sv
testbench/vreadTb.sv
